// File: include/ccu_settings.svh
// build-time sizes of the coherence unit, shared by packages and RTL
// the line length is fixed at two words; the return path is built for that value
`ifndef CCU_SETTINGS_SVH
`define CCU_SETTINGS_SVH

// number of cache ports on the snoop side
`define CCU_NUM_PORTS 4

// address width of the read and snoop channels
`define CCU_ADDR_W 32

// data word width
`define CCU_DATA_W 64

// low id bits chosen by the requesting cache
`define CCU_TAG_W 4

// words per cache line
`define CCU_LINE_WORDS 2

`endif

// File: rtl/ace_pkg.sv
// channel types for the read, snoop and memory sides of the coherence unit
// id upper bits carry the requesting port index
`include "ccu_settings.svh"

package ace_pkg;

    typedef logic [`CCU_ADDR_W-1:0] addr_t;
    typedef logic [`CCU_DATA_W-1:0] data_t;
    // tag from the cache, port index on top
    typedef logic [`CCU_TAG_W+$clog2(`CCU_NUM_PORTS)-1:0] id_t;
    typedef logic [3:0] snoop_t;

    typedef struct packed {
        addr_t  addr;
        id_t    id;
        snoop_t snoop;
    } ar_chan_t;

    typedef struct packed {
        data_t data;
        id_t   id;
        logic  last;
        logic  is_shared;
        logic  pass_dirty;
    } r_chan_t;

    typedef struct packed {
        addr_t  addr;
        snoop_t snoop;
    } ac_chan_t;

    typedef struct packed {
        logic data_transfer;
        logic is_shared;
        logic pass_dirty;
        logic error;
    } cr_resp_t;

    typedef struct packed {
        data_t data;
        logic  last;
    } cd_chan_t;

    typedef struct packed {
        data_t data;
        logic  last;
    } mem_r_chan_t;

endpackage

// File: rtl/ccu_pkg.sv
// internal types of the coherence unit: port masks, controller states, routing
`include "ccu_settings.svh"

package ccu_pkg;

    typedef logic [`CCU_NUM_PORTS-1:0] port_mask_t;
    typedef logic [$clog2(`CCU_NUM_PORTS)-1:0] port_idx_t;

    typedef enum logic [2:0] {
        st_idle,
        st_snoop_send,
        st_snoop_wait,
        st_line_xfer,
        st_mem_req,
        st_mem_read
    } ccu_state_e;

    // origin of the line returned to the requester
    typedef enum logic [1:0] {
        src_none,
        src_snoop,
        src_mem
    } data_src_e;

    // fields only meaningful while source is not none
    typedef struct packed {
        data_src_e  source;
        port_idx_t  first_responder;
        port_mask_t data_ports;
        logic       shared;
        logic       dirty;
    } route_t;

endpackage

// File: rtl/req_intake.sv
// single-slot read request holder; a new request is taken only after done
// the initiator mask is decoded from the held id and is valid while req_valid_o is high
`timescale 1ns/1ps
`include "ccu_settings.svh"

module req_intake (
    input  logic                clk_i,
    input  logic                rst_ni,
    input  logic                ar_valid_i,
    input  ace_pkg::ar_chan_t   ar_i,
    output logic                ar_ready_o,
    input  logic                done_i,
    output logic                req_valid_o,
    output ace_pkg::ar_chan_t   req_o,
    output ccu_pkg::port_mask_t initiator_o
);

    import ace_pkg::*;
    import ccu_pkg::*;

    logic      busy_q;
    logic      accept;
    ar_chan_t  req_q;
    port_idx_t init_idx;

    assign ar_ready_o = ~busy_q;
    assign accept     = ar_valid_i & ar_ready_o;

    // slot occupied from acceptance until the controller reports done
    always_ff @(posedge clk_i, negedge rst_ni) begin
        if (!rst_ni) begin
            busy_q <= 1'b0;
        end else if (accept) begin
            busy_q <= 1'b1;
        end else if (done_i) begin
            busy_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            req_q <= ar_i;
        end
    end

    assign req_valid_o = busy_q;
    assign req_o       = req_q;

    // port index sits right above the cache's own tag bits
    assign init_idx = req_q.id[`CCU_TAG_W +: $bits(port_idx_t)];

    always_comb begin
        initiator_o           = '0;
        initiator_o[init_idx] = 1'b1;
    end

endmodule

// File: rtl/snoop_ctrl.sv
// controller for one read at a time: snoop all other ports, then pick snoop data or memory
// the requesting port is never snooped; its bits are preset in the ack and response masks
`timescale 1ns/1ps
`include "ccu_settings.svh"

module snoop_ctrl (
    input  logic                                     clk_i,
    input  logic                                     rst_ni,
    input  logic                                     req_valid_i,
    input  ace_pkg::ar_chan_t                        req_i,
    input  ccu_pkg::port_mask_t                      initiator_i,
    output ccu_pkg::port_mask_t                      ac_valid_o,
    input  ccu_pkg::port_mask_t                      ac_ready_i,
    output ace_pkg::ac_chan_t                        ac_o,
    input  ccu_pkg::port_mask_t                      cr_valid_i,
    input  ace_pkg::cr_resp_t [`CCU_NUM_PORTS-1:0]   cr_i,
    output ccu_pkg::port_mask_t                      cr_ready_o,
    output logic                                     mem_ar_valid_o,
    output ace_pkg::ar_chan_t                        mem_ar_o,
    input  logic                                     mem_ar_ready_i,
    output ccu_pkg::route_t                          route_o,
    input  logic                                     line_done_i,
    output logic                                     done_o
);

    import ace_pkg::*;
    import ccu_pkg::*;

    ccu_state_e state_d, state_q;
    // sticky per-port masks for the current snoop round
    port_mask_t ac_ack_d, ac_ack_q;
    port_mask_t cr_got_d, cr_got_q;
    port_mask_t data_d, data_q;
    logic       shared_d, shared_q;
    logic       dirty_d, dirty_q;
    port_idx_t  first_idx;

    // ------------------------------------------------------------------------
    // state and sticky masks
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_i, negedge rst_ni) begin
        if (!rst_ni) begin
            state_q  <= st_idle;
            ac_ack_q <= '0;
            cr_got_q <= '0;
            data_q   <= '0;
            shared_q <= 1'b0;
            dirty_q  <= 1'b0;
        end else begin
            state_q  <= state_d;
            ac_ack_q <= ac_ack_d;
            cr_got_q <= cr_got_d;
            data_q   <= data_d;
            shared_q <= shared_d;
            dirty_q  <= dirty_d;
        end
    end

    always_comb begin
        state_d        = state_q;
        ac_ack_d       = ac_ack_q;
        cr_got_d       = cr_got_q;
        data_d         = data_q;
        shared_d       = shared_q;
        dirty_d        = dirty_q;
        ac_valid_o     = '0;
        cr_ready_o     = '0;
        mem_ar_valid_o = 1'b0;
        done_o         = 1'b0;

        case (state_q)
            st_idle: begin
                if (req_valid_i) begin
                    state_d  = st_snoop_send;
                    ac_ack_d = initiator_i;
                    cr_got_d = initiator_i;
                    data_d   = '0;
                    shared_d = 1'b0;
                    dirty_d  = 1'b0;
                end
            end

            st_snoop_send: begin
                // each port drops valid once its own snoop is taken
                ac_valid_o = ~ac_ack_q;
                ac_ack_d   = ac_ack_q | (ac_valid_o & ac_ready_i);
                if (&ac_ack_d) begin
                    state_d = st_snoop_wait;
                end
            end

            st_snoop_wait: begin
                cr_ready_o = ~cr_got_q;
                for (int i = 0; i < `CCU_NUM_PORTS; i++) begin
                    if (cr_valid_i[i] && cr_ready_o[i]) begin
                        cr_got_d[i] = 1'b1;
                        data_d[i]   = cr_i[i].data_transfer & ~cr_i[i].error;
                        shared_d    = shared_d | cr_i[i].is_shared;
                        dirty_d     = dirty_d | cr_i[i].pass_dirty;
                    end
                end
                if (&cr_got_d) begin
                    state_d = (|data_d) ? st_line_xfer : st_mem_req;
                end
            end

            st_mem_req: begin
                mem_ar_valid_o = 1'b1;
                if (mem_ar_ready_i) begin
                    state_d = st_mem_read;
                end
            end

            st_line_xfer, st_mem_read: begin
                if (line_done_i) begin
                    done_o  = 1'b1;
                    state_d = st_idle;
                end
            end

            default: state_d = st_idle;
        endcase
    end

    // ------------------------------------------------------------------------
    // data source selection
    // ------------------------------------------------------------------------
    // lowest-numbered valid data holder wins
    always_comb begin
        first_idx = '0;
        for (int i = `CCU_NUM_PORTS - 1; i >= 0; i--) begin
            if (data_q[i]) begin
                first_idx = port_idx_t'(i);
            end
        end
    end

    always_comb begin
        case (state_q)
            st_line_xfer:            route_o.source = src_snoop;
            st_mem_req, st_mem_read: route_o.source = src_mem;
            default:                 route_o.source = src_none;
        endcase
        route_o.first_responder = first_idx;
        route_o.data_ports      = data_q;
        route_o.shared          = shared_q;
        route_o.dirty           = dirty_q;
    end

    // snoop and memory requests reuse the held request
    assign ac_o.addr  = req_i.addr;
    assign ac_o.snoop = req_i.snoop;
    assign mem_ar_o   = req_i;

endmodule

// File: rtl/line_return.sv
// return path to the requester: snoop line buffer or memory pass-through
// counters clear while the route source is none, so one line per transaction
`timescale 1ns/1ps
`include "ccu_settings.svh"

module line_return (
    input  logic                                   clk_i,
    input  logic                                   rst_ni,
    input  ccu_pkg::route_t                        route_i,
    input  ace_pkg::id_t                           req_id_i,
    input  ccu_pkg::port_mask_t                    cd_valid_i,
    input  ace_pkg::cd_chan_t [`CCU_NUM_PORTS-1:0] cd_i,
    output ccu_pkg::port_mask_t                    cd_ready_o,
    input  logic                                   mem_r_valid_i,
    input  ace_pkg::mem_r_chan_t                   mem_r_i,
    output logic                                   mem_r_ready_o,
    output logic                                   r_valid_o,
    output ace_pkg::r_chan_t                       r_o,
    input  logic                                   r_ready_i,
    output logic                                   line_done_o
);

    import ace_pkg::*;
    import ccu_pkg::*;

    localparam int unsigned WORD_IDX_W = $clog2(`CCU_LINE_WORDS);
    localparam int unsigned CNT_W      = $clog2(`CCU_LINE_WORDS + 1);

    typedef logic [CNT_W-1:0] beat_cnt_t;

    data_t      line_q [`CCU_LINE_WORDS];
    beat_cnt_t  stored_q;
    beat_cnt_t  sent_q;
    port_mask_t last_seen_q;
    port_mask_t cd_fire;
    port_mask_t cd_last;
    logic       snoop_src;
    logic       mem_src;
    logic       fr_fire;
    logic       r_fire;

    assign snoop_src = (route_i.source == src_snoop);
    assign mem_src   = (route_i.source == src_mem);

    // ------------------------------------------------------------------------
    // snoop data intake
    // ------------------------------------------------------------------------
    // every data holder is drained, only the first responder is kept
    assign cd_ready_o = snoop_src ? (route_i.data_ports & ~last_seen_q) : '0;
    assign cd_fire    = cd_valid_i & cd_ready_o;
    assign fr_fire    = cd_fire[route_i.first_responder];

    always_comb begin
        for (int i = 0; i < `CCU_NUM_PORTS; i++) begin
            cd_last[i] = cd_i[i].last;
        end
    end

    // words land in arrival order
    always_ff @(posedge clk_i) begin
        if (fr_fire) begin
            line_q[stored_q[WORD_IDX_W-1:0]] <= cd_i[route_i.first_responder].data;
        end
    end

    always_ff @(posedge clk_i, negedge rst_ni) begin
        if (!rst_ni) begin
            stored_q    <= '0;
            sent_q      <= '0;
            last_seen_q <= '0;
        end else if (route_i.source == src_none) begin
            stored_q    <= '0;
            sent_q      <= '0;
            last_seen_q <= '0;
        end else begin
            if (fr_fire) begin
                stored_q <= stored_q + 1'b1;
            end
            if (r_fire) begin
                sent_q <= sent_q + 1'b1;
            end
            last_seen_q <= last_seen_q | (cd_fire & cd_last);
        end
    end

    // ------------------------------------------------------------------------
    // r channel to the requester
    // ------------------------------------------------------------------------
    always_comb begin
        r_valid_o = 1'b0;
        r_o       = '0;
        r_o.id    = req_id_i;
        if (snoop_src) begin
            // beat k goes out once word k is in the buffer
            r_valid_o      = (sent_q < stored_q);
            r_o.data       = line_q[sent_q[WORD_IDX_W-1:0]];
            r_o.last       = (sent_q == beat_cnt_t'(`CCU_LINE_WORDS - 1));
            r_o.is_shared  = route_i.shared;
            r_o.pass_dirty = route_i.dirty;
        end else if (mem_src) begin
            // memory data carries no coherence flags
            r_valid_o = mem_r_valid_i;
            r_o.data  = mem_r_i.data;
            r_o.last  = mem_r_i.last;
        end
    end

    assign mem_r_ready_o = mem_src & r_ready_i;
    assign r_fire        = r_valid_o & r_ready_i;

    // full line sent and all extra holders drained
    assign line_done_o = (snoop_src | mem_src)
                       & (sent_q == beat_cnt_t'(`CCU_LINE_WORDS))
                       & (last_seen_q == route_i.data_ports);

endmodule

// File: rtl/ccu_top.sv
// read-only snoop coherence unit with one request port, per-cache snoop ports and memory
// one transaction in flight; a single snoop request is broadcast to all ports
`timescale 1ns/1ps
`include "ccu_settings.svh"

module ccu_top (
    input  logic                                   clk_i,
    input  logic                                   rst_ni,
    // read request from a cache
    input  logic                                   ar_valid_i,
    input  ace_pkg::ar_chan_t                      ar_i,
    output logic                                   ar_ready_o,
    // line back to the requester
    output logic                                   r_valid_o,
    output ace_pkg::r_chan_t                       r_o,
    input  logic                                   r_ready_i,
    // snoop channels
    output ccu_pkg::port_mask_t                    ac_valid_o,
    input  ccu_pkg::port_mask_t                    ac_ready_i,
    output ace_pkg::ac_chan_t                      ac_o,
    input  ccu_pkg::port_mask_t                    cr_valid_i,
    input  ace_pkg::cr_resp_t [`CCU_NUM_PORTS-1:0] cr_i,
    output ccu_pkg::port_mask_t                    cr_ready_o,
    input  ccu_pkg::port_mask_t                    cd_valid_i,
    input  ace_pkg::cd_chan_t [`CCU_NUM_PORTS-1:0] cd_i,
    output ccu_pkg::port_mask_t                    cd_ready_o,
    // memory
    output logic                                   mem_ar_valid_o,
    output ace_pkg::ar_chan_t                      mem_ar_o,
    input  logic                                   mem_ar_ready_i,
    input  logic                                   mem_r_valid_i,
    input  ace_pkg::mem_r_chan_t                   mem_r_i,
    output logic                                   mem_r_ready_o
);

    import ace_pkg::*;
    import ccu_pkg::*;

    logic       req_valid;
    ar_chan_t   req;
    port_mask_t initiator;
    route_t     route;
    logic       line_done;
    logic       done;

    req_intake req_intake_i (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .ar_valid_i  (ar_valid_i),
        .ar_i        (ar_i),
        .ar_ready_o  (ar_ready_o),
        .done_i      (done),
        .req_valid_o (req_valid),
        .req_o       (req),
        .initiator_o (initiator)
    );

    snoop_ctrl snoop_ctrl_i (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .req_valid_i    (req_valid),
        .req_i          (req),
        .initiator_i    (initiator),
        .ac_valid_o     (ac_valid_o),
        .ac_ready_i     (ac_ready_i),
        .ac_o           (ac_o),
        .cr_valid_i     (cr_valid_i),
        .cr_i           (cr_i),
        .cr_ready_o     (cr_ready_o),
        .mem_ar_valid_o (mem_ar_valid_o),
        .mem_ar_o       (mem_ar_o),
        .mem_ar_ready_i (mem_ar_ready_i),
        .route_o        (route),
        .line_done_i    (line_done),
        .done_o         (done)
    );

    line_return line_return_i (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .route_i       (route),
        .req_id_i      (req.id),
        .cd_valid_i    (cd_valid_i),
        .cd_i          (cd_i),
        .cd_ready_o    (cd_ready_o),
        .mem_r_valid_i (mem_r_valid_i),
        .mem_r_i       (mem_r_i),
        .mem_r_ready_o (mem_r_ready_o),
        .r_valid_o     (r_valid_o),
        .r_o           (r_o),
        .r_ready_i     (r_ready_i),
        .line_done_o   (line_done)
    );

endmodule

// File: sim/tb_ccu.sv
// testbench for ccu_top with cache and memory models and random reads from an LFSR
// the fork in the test loop starts one cache model per port and assumes four ports
`timescale 1ns/1ps
`include "ccu_settings.svh"

module tb_ccu;

    import ace_pkg::*;
    import ccu_pkg::*;

    localparam int unsigned NP       = `CCU_NUM_PORTS;
    localparam int unsigned LINE     = `CCU_LINE_WORDS;
    localparam int unsigned NUM_TEST = 48;
    localparam int unsigned TMO      = 400;

    typedef struct packed {
        logic                  from_mem;
        data_t [LINE-1:0]      words;
        logic                  shared;
        logic                  dirty;
        logic [1:0]            mem_reqs;
    } expect_t;

    logic clk_i;
    logic rst_ni;
    logic ar_valid_i;
    ar_chan_t ar_i;
    logic ar_ready_o;
    logic r_valid_o;
    r_chan_t r_o;
    logic r_ready_i;
    port_mask_t ac_valid_o;
    port_mask_t ac_ready_i;
    ac_chan_t ac_o;
    port_mask_t cr_valid_i;
    cr_resp_t [NP-1:0] cr_i;
    port_mask_t cr_ready_o;
    port_mask_t cd_valid_i;
    cd_chan_t [NP-1:0] cd_i;
    port_mask_t cd_ready_o;
    logic mem_ar_valid_o;
    ar_chan_t mem_ar_o;
    logic mem_ar_ready_i;
    logic mem_r_valid_i;
    mem_r_chan_t mem_r_i;
    logic mem_r_ready_o;

    // per-test stimulus and expectation
    logic [31:0]       lfsr_q = 32'h9f95_cc61;
    int unsigned       init_port;
    addr_t             req_addr;
    id_t               req_id;
    cr_resp_t [NP-1:0] resp;
    int unsigned       ac_dly[NP];
    int unsigned       cr_dly[NP];
    int unsigned       cd_dly[NP][LINE];
    int unsigned       mem_dly;
    logic [15:0]       stall_mask;
    expect_t           exp_line;
    int unsigned       ac_seen[NP];
    int unsigned       mem_seen;
    logic              in_flight = 1'b0;
    logic              line_seen = 1'b0;
    logic              r_stalled = 1'b0;
    r_chan_t           r_held;
    int unsigned       errors = 0;

    ccu_top ccu_top_i (.*);

    always #2 clk_i = ~clk_i;

    // ------------------------------------------------------------------------
    // random source, data patterns and reference
    // ------------------------------------------------------------------------
    function automatic logic [31:0] draw(int unsigned n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v      = {v[30:0], lfsr_q[0]};
            lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h8020_0003) : (lfsr_q >> 1);
        end
        return v;
    endfunction

    function automatic data_t cache_word(int unsigned p, addr_t a, int unsigned k);
        return {8'hca, 4'(p), 4'(k), a, a[15:0] ^ 16'h5a5a};
    endfunction

    function automatic data_t mem_word(addr_t a, int unsigned k);
        return {8'h3e, 4'hf, 4'(k), ~a, a[31:16]};
    endfunction

    function automatic expect_t ref_line(int unsigned init, addr_t a, cr_resp_t [NP-1:0] cr);
        expect_t e;
        int      first;
        e     = '0;
        first = -1;
        // the first holder found going up is the lowest one
        for (int p = 0; p < NP; p++) begin
            if (p != init) begin
                e.shared = e.shared | cr[p].is_shared;
                e.dirty  = e.dirty | cr[p].pass_dirty;
                if (first < 0 && cr[p].data_transfer && !cr[p].error) begin
                    first = p;
                end
            end
        end
        for (int k = 0; k < LINE; k++) begin
            e.words[k] = (first >= 0) ? cache_word(first, a, k) : mem_word(a, k);
        end
        if (first < 0) begin
            e.from_mem = 1'b1;
            e.mem_reqs = 2'd1;
            e.shared   = 1'b0;
            e.dirty    = 1'b0;
        end
        return e;
    endfunction

    // ------------------------------------------------------------------------
    // compare tasks and timing helpers
    // ------------------------------------------------------------------------
    task automatic check_data(string name, data_t got, data_t exp);
        if (got !== exp) begin
            errors++;
            $display("ERR t=%0t %s got %h exp %h", $time, name, got, exp);
        end
    endtask

    task automatic check_id(string name, id_t got, id_t exp);
        if (got !== exp) begin
            errors++;
            $display("ERR t=%0t %s got %h exp %h", $time, name, got, exp);
        end
    endtask

    task automatic check_addr(string name, addr_t got, addr_t exp);
        if (got !== exp) begin
            errors++;
            $display("ERR t=%0t %s got %h exp %h", $time, name, got, exp);
        end
    endtask

    task automatic check_flag(string name, logic got, logic exp);
        if (got !== exp) begin
            errors++;
            $display("ERR t=%0t %s got %b exp %b", $time, name, got, exp);
        end
    endtask

    task automatic check_mask(string name, port_mask_t got, port_mask_t exp);
        if (got !== exp) begin
            errors++;
            $display("ERR t=%0t %s got %b exp %b", $time, name, got, exp);
        end
    endtask

    task automatic check_count(string name, int unsigned got, int unsigned exp);
        if (got != exp) begin
            errors++;
            $display("ERR t=%0t %s got %0d exp %0d", $time, name, got, exp);
        end
    endtask

    task automatic abort_run(string why);
        $display("timeout at %0t: %s", $time, why);
        $display("STATUS: FAIL");
        $finish;
    endtask

    // inputs change half a nanosecond after the rising edge
    task automatic step(int unsigned n);
        repeat (n) begin
            @(posedge clk_i);
            #0.5;
        end
    endtask

    // outputs are sampled on the falling edge
    task automatic tick_wait(inout int unsigned t, input string what);
        @(negedge clk_i);
        t++;
        if (t > TMO) begin
            abort_run(what);
        end
    endtask

    // ------------------------------------------------------------------------
    // bus models
    // ------------------------------------------------------------------------
    task automatic send_request();
        int unsigned t;
        t          = 0;
        ar_valid_i = 1'b1;
        ar_i       = '{addr: req_addr, id: req_id, snoop: 4'h0};
        do tick_wait(t, "the read request was never accepted"); while (!ar_ready_o);
        step(1);
        ar_valid_i = 1'b0;
        ar_i       = '0;
        in_flight  = 1'b1;
    endtask

    task automatic serve_cache(int unsigned p);
        int unsigned t;
        if (p == init_port) begin
            // requester stays ready, so a stray snoop gets counted
            ac_ready_i[p] = 1'b1;
            return;
        end
        t = 0;
        do tick_wait(t, $sformatf("port %0d never got a snoop", p)); while (!ac_valid_o[p]);
        step(1 + ac_dly[p]);
        ac_ready_i[p] = 1'b1;
        step(1);
        ac_ready_i[p] = 1'b0;
        step(cr_dly[p]);
        cr_valid_i[p] = 1'b1;
        cr_i[p]       = resp[p];
        t = 0;
        do tick_wait(t, $sformatf("port %0d response never taken", p)); while (!cr_ready_o[p]);
        step(1);
        cr_valid_i[p] = 1'b0;
        if (!resp[p].data_transfer || resp[p].error) begin
            return;
        end
        for (int k = 0; k < LINE; k++) begin
            step(cd_dly[p][k]);
            cd_valid_i[p] = 1'b1;
            cd_i[p]       = '{data: cache_word(p, req_addr, k), last: (k == LINE - 1)};
            t = 0;
            do tick_wait(t, $sformatf("port %0d data never taken", p)); while (!cd_ready_o[p]);
            step(1);
            cd_valid_i[p] = 1'b0;
        end
    endtask

    task automatic serve_memory();
        int unsigned t;
        addr_t       a;
        t = 0;
        do tick_wait(t, "neither a memory read nor a full line came");
        while (!mem_ar_valid_o && !line_seen);
        if (!mem_ar_valid_o) begin
            step(1);
            return;
        end
        a = mem_ar_o.addr;
        step(1 + mem_dly);
        mem_ar_ready_i = 1'b1;
        step(1);
        mem_ar_ready_i = 1'b0;
        for (int k = 0; k < LINE; k++) begin
            step(mem_dly);
            mem_r_valid_i = 1'b1;
            mem_r_i       = '{data: mem_word(a, k), last: (k == LINE - 1)};
            t = 0;
            do tick_wait(t, "a memory beat was never taken"); while (!mem_r_ready_o);
            step(1);
            mem_r_valid_i = 1'b0;
        end
    endtask

    // requester model that compares every beat as it is taken
    task automatic collect_line();
        int unsigned t;
        int unsigned k;
        t         = 0;
        k         = 0;
        r_ready_i = stall_mask[0];
        while (k < LINE) begin
            tick_wait(t, "no complete line reached the requester");
            if (r_valid_o && r_ready_i) begin
                check_data("r_o.data", r_o.data, exp_line.words[k]);
                check_id("r_o.id", r_o.id, req_id);
                check_flag("r_o.last", r_o.last, k == LINE - 1);
                check_flag("r_o.is_shared", r_o.is_shared, exp_line.shared);
                check_flag("r_o.pass_dirty", r_o.pass_dirty, exp_line.dirty);
                k++;
            end
            step(1);
            r_ready_i = stall_mask[t % 16];
        end
        r_ready_i = 1'b0;
        in_flight = 1'b0;
        line_seen = 1'b1;
    endtask

    // protocol monitor
    always @(negedge clk_i) begin
        if (rst_ni) begin
            for (int p = 0; p < NP; p++) begin
                // a port that already took its snoop must not be offered another
                if (ac_valid_o[p] && ac_seen[p] != 0) begin
                    errors++;
                    $display("t=%0t port %0d was offered a second snoop", $time, p);
                end
                if (ac_valid_o[p] && ac_ready_i[p]) begin
                    ac_seen[p]++;
                    check_addr("ac_o.addr", ac_o.addr, req_addr);
                end
            end
            if (mem_ar_valid_o && mem_ar_ready_i) begin
                mem_seen++;
                check_addr("mem_ar_o.addr", mem_ar_o.addr, req_addr);
                check_id("mem_ar_o.id", mem_ar_o.id, req_id);
            end
            if (in_flight && ar_ready_o) begin
                errors++;
                $display("t=%0t ar_ready_o went high while a read was outstanding", $time);
            end
            if (!in_flight && r_valid_o) begin
                errors++;
                $display("t=%0t r_valid_o went high with no read outstanding", $time);
            end
            if (r_stalled && !r_valid_o) begin
                errors++;
                $display("t=%0t r_valid_o dropped before the beat was taken", $time);
            end else if (r_stalled) begin
                check_data("r_o.data held", r_o.data, r_held.data);
            end
            r_stalled = r_valid_o && !r_ready_i;
            r_held    = r_o;
        end
    end

    // ------------------------------------------------------------------------
    // test sequence
    // ------------------------------------------------------------------------
    initial begin
        logic [31:0] rnd;
        int unsigned t;
        int unsigned tag;
        int unsigned holders;
        int unsigned err_before;
        int unsigned failed;
        int unsigned mem_tests;
        int unsigned multi;
        failed         = 0;
        mem_tests      = 0;
        multi          = 0;
        clk_i          = 1'b0;
        rst_ni         = 1'b0;
        ar_valid_i     = 1'b0;
        ar_i           = '0;
        r_ready_i      = 1'b0;
        ac_ready_i     = '0;
        cr_valid_i     = '0;
        cr_i           = '0;
        cd_valid_i     = '0;
        cd_i           = '0;
        mem_ar_ready_i = 1'b0;
        mem_r_valid_i  = 1'b0;
        mem_r_i        = '0;
        repeat (4) @(posedge clk_i);
        #0.5;
        rst_ni = 1'b1;

        @(negedge clk_i);
        check_flag("ar_ready_o", ar_ready_o, 1'b1);
        check_flag("r_valid_o", r_valid_o, 1'b0);
        check_flag("mem_ar_valid_o", mem_ar_valid_o, 1'b0);
        check_flag("mem_r_ready_o", mem_r_ready_o, 1'b0);
        check_mask("ac_valid_o", ac_valid_o, '0);
        check_mask("cr_ready_o", cr_ready_o, '0);
        check_mask("cd_ready_o", cd_ready_o, '0);
        $display("test reset: %s", (errors == 0) ? "ok" : "mismatch");
        if (errors != 0) begin
            failed++;
        end
        step(1);

        for (int n = 0; n < NUM_TEST; n++) begin
            err_before = errors;
            init_port  = draw(2);
            tag        = draw(`CCU_TAG_W);
            req_addr   = draw(`CCU_ADDR_W) & ~32'hf;
            req_id     = {port_idx_t'(init_port), tag[`CCU_TAG_W-1:0]};
            resp       = '0;
            holders    = 0;
            for (int p = 0; p < NP; p++) begin
                if (p != init_port) begin
                    resp[p].data_transfer = (draw(1) != 0);
                    resp[p].error         = (draw(2) == 0);
                    resp[p].is_shared     = (draw(1) != 0);
                    resp[p].pass_dirty    = (draw(1) != 0);
                    if (resp[p].data_transfer && !resp[p].error) begin
                        holders++;
                    end
                end
                ac_dly[p]    = draw(2);
                cr_dly[p]    = draw(2);
                cd_dly[p][0] = draw(2);
                cd_dly[p][1] = draw(2);
                ac_seen[p]   = 0;
            end
            mem_dly    = draw(2);
            rnd        = draw(16);
            stall_mask = rnd[15:0] | 16'h8001;
            exp_line   = ref_line(init_port, req_addr, resp);
            mem_seen   = 0;
            ac_ready_i = '0;
            line_seen  = 1'b0;

            fork
                send_request();
                serve_cache(0);
                serve_cache(1);
                serve_cache(2);
                serve_cache(3);
                serve_memory();
                collect_line();
            join

            for (int p = 0; p < NP; p++) begin
                check_count($sformatf("snoops to port %0d", p), ac_seen[p],
                            (p == init_port) ? 0 : 1);
            end
            check_count("memory reads", mem_seen, exp_line.mem_reqs);
            if (exp_line.from_mem) begin
                mem_tests++;
            end
            if (holders > 1) begin
                multi++;
            end
            if (errors != err_before) begin
                failed++;
            end
            $display("test %2d: port %0d addr %h holders %0d from %s: %s", n, init_port,
                     req_addr, holders, exp_line.from_mem ? "memory" : "snoop",
                     (errors == err_before) ? "ok" : "mismatch");
        end

        // last read must release the request slot
        t = 0;
        do tick_wait(t, "the last read never released the request slot"); while (!ar_ready_o);
        $display("tests %0d passed %0d failed %0d errors %0d memory %0d multi-holder %0d",
                 NUM_TEST + 1, NUM_TEST + 1 - failed, failed, errors, mem_tests, multi);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// File: sim.f
+incdir+include
rtl/ace_pkg.sv
rtl/ccu_pkg.sv
rtl/req_intake.sv
rtl/snoop_ctrl.sv
rtl/line_return.sv
rtl/ccu_top.sv
sim/tb_ccu.sv

// File: run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_ccu -f sim.f -o tb_ccu
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/tb_ccu)
rc=$?
echo "$out"
if [ $rc -ne 0 ]; then
    echo "simulation exited with status $rc"
    exit 1
fi

if echo "$out" | grep -q "^STATUS: PASS$"; then
    exit 0
fi
exit 1
